// File: build.f
hdl/max7219_pkg.sv
hdl/max7219_sequencer.sv
hdl/max7219_frame_encoder.sv
hdl/max7219_spi_shifter.sv
hdl/max7219_driver.sv
sim/tb_clock_gen.sv
sim/tb_max7219_driver.sv

// File: hdl/max7219_driver.sv
module max7219_driver
    import max7219_pkg::*;
#(
    parameter int SEG_ROWS      = 1,
    parameter int SEG_COLS      = 1,
    parameter int SPI_CYCLES    = 4,
    parameter int UPDATE_CYCLES = 1000
) (
    input  logic                                         i_clk,
    input  logic                                         i_rst_n,
    input  logic [DEV_SIDE*DEV_SIDE*SEG_ROWS*SEG_COLS-1:0] i_frame,
    input  intensity_t [SEG_ROWS*SEG_COLS-1:0]           i_intensity,
    output logic                                         o_spi_stb,
    output logic                                         o_spi_clk,
    output logic                                         o_spi_din
);

    // One device frame per matrix in the chain
    localparam int WIDTH = DEV_BITS * SEG_ROWS * SEG_COLS;

    cmd_t             cmd;
    logic             cmd_stb;
    logic             slot_free;
    logic [WIDTH-1:0] word;
    logic             word_stb;
    logic             busy;

    max7219_sequencer #(
        .UPDATE_CYCLES (UPDATE_CYCLES)
    ) u_sequencer (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_slot_free (slot_free),
        .o_cmd       (cmd),
        .o_cmd_stb   (cmd_stb)
    );

    max7219_frame_encoder #(
        .SEG_ROWS (SEG_ROWS),
        .SEG_COLS (SEG_COLS),
        .WIDTH    (WIDTH)
    ) u_encoder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd       (cmd),
        .i_cmd_stb   (cmd_stb),
        .i_frame     (i_frame),
        .i_intensity (i_intensity),
        .i_busy      (busy),
        .o_slot_free (slot_free),
        .o_word      (word),
        .o_word_stb  (word_stb)
    );

    max7219_spi_shifter #(
        .WIDTH      (WIDTH),
        .SPI_CYCLES (SPI_CYCLES)
    ) u_shifter (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_word     (word),
        .i_word_stb (word_stb),
        .o_busy     (busy),
        .o_spi_stb  (o_spi_stb),
        .o_spi_clk  (o_spi_clk),
        .o_spi_din  (o_spi_din)
    );

endmodule

// File: hdl/max7219_frame_encoder.sv
module max7219_frame_encoder
    import max7219_pkg::*;
#(
    parameter int SEG_ROWS = 1,
    parameter int SEG_COLS = 1,
    parameter int WIDTH    = DEV_BITS * SEG_ROWS * SEG_COLS
) (
    input  logic                                         i_clk,
    input  logic                                         i_rst_n,
    input  cmd_t                                         i_cmd,
    input  logic                                         i_cmd_stb,
    input  logic [DEV_SIDE*DEV_SIDE*SEG_ROWS*SEG_COLS-1:0] i_frame,
    input  intensity_t [SEG_ROWS*SEG_COLS-1:0]           i_intensity,
    input  logic                                         i_busy,
    output logic                                         o_slot_free,
    output logic [WIDTH-1:0]                             o_word,
    output logic                                         o_word_stb
);

    localparam int NUM_DEV  = SEG_ROWS * SEG_COLS;
    localparam int FB_XSIZE = DEV_SIDE * SEG_COLS;
    localparam int FB_BITS  = DEV_SIDE * DEV_SIDE * NUM_DEV;

    logic [FB_BITS-1:0]        frame_q;
    intensity_t [NUM_DEV-1:0]  level_q;
    logic [WIDTH-1:0]          word_d;
    logic [WIDTH-1:0]          word_q;
    logic                      full;

    // ------------------------------------------------------------------
    // One device frame per matrix, device (r, c) at slot r*SEG_COLS + c
    // ------------------------------------------------------------------
    always_comb begin
        reg_addr_t addr;
        reg_data_t data;
        int        dev;
        int        y;
        word_d = '0;
        for (int r = 0; r < SEG_ROWS; r++) begin
            for (int c = 0; c < SEG_COLS; c++) begin
                dev  = r * SEG_COLS + c;
                y    = DEV_SIDE * r + int'(i_cmd.row);
                addr = REG_DIGIT0 + reg_addr_t'(i_cmd.row);
                // Leftmost pixel goes to the data MSB
                for (int p = 0; p < DEV_SIDE; p++) begin
                    data[DEV_SIDE-1-p] = frame_q[y * FB_XSIZE + DEV_SIDE * c + p];
                end
                case (i_cmd.kind)
                    CMD_SHUTDOWN:  begin addr = REG_SHUTDOWN;  data = DATA_SHUTDOWN;  end
                    CMD_NORMAL:    begin addr = REG_SHUTDOWN;  data = DATA_NORMAL;    end
                    CMD_NO_TEST:   begin addr = REG_TEST;      data = DATA_NO_TEST;   end
                    CMD_NO_DECODE: begin addr = REG_DECODE;    data = DATA_NO_DECODE; end
                    CMD_SCAN:      begin addr = REG_SCAN;      data = DATA_SCAN_ALL;  end
                    CMD_INTENSITY: begin
                        addr = REG_INTENSITY;
                        data = {4'b0000, level_q[dev]};
                    end
                    default:       data = data;
                endcase
                word_d[DEV_BITS*dev +: DEV_BITS] = dev_word(addr, data);
            end
        end
    end

    // Output slot
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            full <= 1'b0;
        end else if (i_cmd_stb) begin
            full <= 1'b1;
        end else if (o_word_stb) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_cmd_stb) begin
            word_q <= word_d;
        end
        // Rows of this pass show the frame seen at the scan command
        if (i_cmd_stb && i_cmd.kind == CMD_SCAN) begin
            frame_q <= i_frame;
            level_q <= i_intensity;
        end
    end

    assign o_word      = word_q;
    assign o_word_stb  = full && !i_busy;
    assign o_slot_free = !full;

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cmd_stb |-> !full);

endmodule

// File: hdl/max7219_pkg.sv
package max7219_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------

    // Bits in one device frame on the chain
    localparam int DEV_BITS = 16;
    // Rows and columns of one 8x8 matrix
    localparam int DEV_SIDE = 8;

    typedef logic [3:0]  reg_addr_t;
    typedef logic [7:0]  reg_data_t;
    typedef logic [15:0] dev_word_t;
    typedef logic [3:0]  intensity_t;
    typedef logic [2:0]  row_idx_t;

    // ------------------------------------------------------------------
    // MAX7219 registers and data codes
    // ------------------------------------------------------------------

    localparam reg_addr_t REG_DIGIT0    = 4'h1;
    localparam reg_addr_t REG_DECODE    = 4'h9;
    localparam reg_addr_t REG_INTENSITY = 4'hA;
    localparam reg_addr_t REG_SCAN      = 4'hB;
    localparam reg_addr_t REG_SHUTDOWN  = 4'hC;
    localparam reg_addr_t REG_TEST      = 4'hF;

    localparam reg_data_t DATA_SHUTDOWN  = 8'h00;
    localparam reg_data_t DATA_NORMAL    = 8'h01;
    localparam reg_data_t DATA_NO_TEST   = 8'h00;
    localparam reg_data_t DATA_NO_DECODE = 8'h00;
    localparam reg_data_t DATA_SCAN_ALL  = 8'h07;

    // Commands passed from the sequencer to the encoder
    typedef enum logic [2:0] {
        CMD_SHUTDOWN,
        CMD_NORMAL,
        CMD_NO_TEST,
        CMD_NO_DECODE,
        CMD_SCAN,
        CMD_INTENSITY,
        CMD_ROW
    } cmd_kind_t;

    typedef struct packed {
        cmd_kind_t kind;
        row_idx_t  row;
    } cmd_t;

    // Zero header, then address, then data
    function automatic dev_word_t dev_word(reg_addr_t addr, reg_data_t data);
        return {4'b0000, addr, data};
    endfunction

endpackage

// File: hdl/max7219_sequencer.sv
module max7219_sequencer
    import max7219_pkg::*;
#(
    parameter int UPDATE_CYCLES = 1000
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_slot_free,
    output cmd_t o_cmd,
    output logic o_cmd_stb
);

    localparam int PAUSE_W = $clog2(UPDATE_CYCLES + 1);
    localparam logic [PAUSE_W-1:0] PAUSE_LAST = PAUSE_W'(UPDATE_CYCLES - 1);

    typedef enum logic [2:0] {
        ST_SHUTDOWN,
        ST_NORMAL,
        ST_NO_TEST,
        ST_NO_DECODE,
        ST_SCAN,
        ST_INTENSITY,
        ST_ROW,
        ST_PAUSE
    } state_t;

    state_t             state;
    row_idx_t           row;
    logic [PAUSE_W-1:0] pause_cnt;
    cmd_kind_t          kind;
    logic               issue;

    // Command that goes with each state
    always_comb begin
        case (state)
            ST_SHUTDOWN:  kind = CMD_SHUTDOWN;
            ST_NORMAL:    kind = CMD_NORMAL;
            ST_NO_TEST:   kind = CMD_NO_TEST;
            ST_NO_DECODE: kind = CMD_NO_DECODE;
            ST_SCAN:      kind = CMD_SCAN;
            ST_INTENSITY: kind = CMD_INTENSITY;
            default:      kind = CMD_ROW;
        endcase
    end

    // The strobe of the previous cycle has not yet shown up in the
    // encoder's slot level, so skip one cycle after each command
    assign issue = i_slot_free && !o_cmd_stb && (state != ST_PAUSE);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state     <= ST_SHUTDOWN;
            row       <= '0;
            pause_cnt <= '0;
            o_cmd_stb <= 1'b0;
        end else begin
            o_cmd_stb <= issue;
            if (issue) begin
                case (state)
                    ST_SHUTDOWN:  state <= ST_NORMAL;
                    ST_NORMAL:    state <= ST_NO_TEST;
                    ST_NO_TEST:   state <= ST_NO_DECODE;
                    ST_NO_DECODE: state <= ST_SCAN;
                    ST_SCAN:      state <= ST_INTENSITY;
                    ST_INTENSITY: state <= ST_ROW;
                    ST_ROW: begin
                        row <= row + 1'b1;
                        if (row == 3'd7) begin
                            state <= ST_PAUSE;
                        end
                    end
                    default:      state <= state;
                endcase
            end
            // Pause only counts, the display keeps its last frame
            if (state == ST_PAUSE) begin
                if (pause_cnt == PAUSE_LAST) begin
                    pause_cnt <= '0;
                    state     <= ST_SHUTDOWN;
                end else begin
                    pause_cnt <= pause_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue) begin
            o_cmd.kind <= kind;
            o_cmd.row  <= row;
        end
    end

    // Encoder must have room for every command
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_cmd_stb |-> i_slot_free);

endmodule

// File: hdl/max7219_spi_shifter.sv
module max7219_spi_shifter #(
    parameter int WIDTH      = 16,
    parameter int SPI_CYCLES = 4
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic [WIDTH-1:0] i_word,
    input  logic             i_word_stb,
    output logic             o_busy,
    output logic             o_spi_stb,
    output logic             o_spi_clk,
    output logic             o_spi_din
);

    localparam int HALF_W = $clog2(SPI_CYCLES + 1);
    localparam int BIT_W  = $clog2(WIDTH + 1);
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(SPI_CYCLES - 1);
    localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(WIDTH - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_LOAD
    } state_t;

    state_t            state;
    logic [WIDTH-1:0]  sr;
    logic [HALF_W-1:0] half_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic              load;
    logic              half_end;
    logic              last_bit;
    logic              next_bit;

    assign o_busy   = (state == ST_SHIFT);
    assign load     = i_word_stb && !o_busy;
    assign half_end = (half_cnt == HALF_LAST);
    assign last_bit = (bit_cnt == BIT_LAST);
    // Falling SPI clock that moves on to the following bit
    assign next_bit = (state == ST_SHIFT) && half_end && o_spi_clk && !last_bit;

    // ------------------------------------------------------------------
    // Bit timing, low half then high half per bit, MSB first
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state     <= ST_IDLE;
            half_cnt  <= '0;
            bit_cnt   <= '0;
            o_spi_stb <= 1'b1;
            o_spi_clk <= 1'b0;
            o_spi_din <= 1'b0;
        end else if (load) begin
            // A word can follow straight from the load cycle
            state     <= ST_SHIFT;
            half_cnt  <= '0;
            bit_cnt   <= '0;
            o_spi_stb <= 1'b0;
            o_spi_clk <= 1'b0;
            o_spi_din <= i_word[WIDTH-1];
        end else begin
            case (state)
                ST_SHIFT: begin
                    if (!half_end) begin
                        half_cnt <= half_cnt + 1'b1;
                    end else begin
                        half_cnt <= '0;
                        if (!o_spi_clk) begin
                            o_spi_clk <= 1'b1;
                        end else begin
                            o_spi_clk <= 1'b0;
                            if (last_bit) begin
                                // Chain latches its shift registers here
                                state     <= ST_LOAD;
                                o_spi_stb <= 1'b1;
                            end else begin
                                bit_cnt   <= bit_cnt + 1'b1;
                                o_spi_din <= sr[WIDTH-2];
                            end
                        end
                    end
                end
                ST_LOAD: state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (load) begin
            sr <= i_word;
        end else if (next_bit) begin
            sr <= {sr[WIDTH-2:0], 1'b0};
        end
    end

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_word_stb |-> !o_busy);

    // Load edge must not coincide with a high SPI clock
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_spi_stb) |-> !o_spi_clk);

endmodule

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_max7219_driver -f build.f \
    -o tb_max7219_driver --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_max7219_driver)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: sim/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 2
) (
    input  logic i_rst_req,
    output logic o_clk,
    output logic o_rst_n
);

    logic init_done;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // Power-on reset, released just after a rising edge
    initial begin
        init_done = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        init_done = 1'b1;
    end

    assign o_rst_n = init_done && !i_rst_req;

endmodule

// File: sim/tb_max7219_driver.sv
module tb_max7219_driver
    import max7219_pkg::*;
();

    localparam int SEG_ROWS       = 1;
    localparam int SEG_COLS       = 2;
    localparam int SPI_CYCLES     = 2;
    localparam int UPDATE_CYCLES  = 20;
    localparam int NUM_DEV        = SEG_ROWS * SEG_COLS;
    localparam int WIDTH          = DEV_BITS * NUM_DEV;
    localparam int FB_XSIZE       = DEV_SIDE * SEG_COLS;
    localparam int FB_BITS        = DEV_SIDE * DEV_SIDE * NUM_DEV;
    localparam int WORDS_PER_PASS = 14;
    localparam int NUM_ENTRIES    = 4;
    localparam int WORD_CYCLES    = 2 * SPI_CYCLES * WIDTH + 1;
    // All passes, plus the reset test and some slack
    localparam int LIMIT_CYCLES   = NUM_ENTRIES * (WORDS_PER_PASS * WORD_CYCLES + UPDATE_CYCLES)
                                    + 3 * WORD_CYCLES + 200;

    typedef logic [WIDTH-1:0]   chain_word_t;
    typedef logic [FB_BITS-1:0] frame_t;

    typedef struct packed {
        frame_t                   frame;
        intensity_t [NUM_DEV-1:0] levels;
        logic                     change_mid;
    } stim_t;

    logic                     clk;
    logic                     rst_n;
    logic                     rst_req;
    frame_t                   frame;
    intensity_t [NUM_DEV-1:0] intensity;
    logic                     spi_stb;
    logic                     spi_clk;
    logic                     spi_din;

    stim_t       stim_table [NUM_ENTRIES];
    chain_word_t word_fifo[$];
    int          bits_fifo[$];
    chain_word_t cap_word;
    int          cap_bits;
    logic        prev_clk;
    logic        prev_stb;
    int          seed;

    tb_clock_gen #(
        .PERIOD       (10),
        .RESET_CYCLES (2)
    ) u_clock (
        .i_rst_req (rst_req),
        .o_clk     (clk),
        .o_rst_n   (rst_n)
    );

    max7219_driver #(
        .SEG_ROWS      (SEG_ROWS),
        .SEG_COLS      (SEG_COLS),
        .SPI_CYCLES    (SPI_CYCLES),
        .UPDATE_CYCLES (UPDATE_CYCLES)
    ) dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_frame     (frame),
        .i_intensity (intensity),
        .o_spi_stb   (spi_stb),
        .o_spi_clk   (spi_clk),
        .o_spi_din   (spi_din)
    );

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------

    task automatic stop_on_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_dev_word(string name, dev_word_t got, dev_word_t exp);
        if (got !== exp) begin
            $display("error t=%0t %s got=%h exp=%h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bits(string name, int got, int exp);
        if (got != exp) begin
            $display("error t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_level(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("error t=%0t %s got=%b exp=%b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_word(string what, chain_word_t got, chain_word_t exp);
        for (int d = 0; d < NUM_DEV; d++) begin
            check_dev_word($sformatf("%s dev %0d", what, d),
                           got[DEV_BITS*d +: DEV_BITS], exp[DEV_BITS*d +: DEV_BITS]);
        end
    endtask

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    // Command order within one pass of the sequence
    function automatic cmd_t pass_cmd(int w);
        cmd_t cmd;
        cmd.row = '0;
        case (w)
            0: cmd.kind = CMD_SHUTDOWN;
            1: cmd.kind = CMD_NORMAL;
            2: cmd.kind = CMD_NO_TEST;
            3: cmd.kind = CMD_NO_DECODE;
            4: cmd.kind = CMD_SCAN;
            5: cmd.kind = CMD_INTENSITY;
            default: begin
                cmd.kind = CMD_ROW;
                cmd.row  = row_idx_t'(w - 6);
            end
        endcase
        return cmd;
    endfunction

    function automatic chain_word_t expected_word(cmd_t cmd, stim_t s);
        chain_word_t w;
        dev_word_t   fr;
        reg_data_t   row_bits;
        int          dev;
        int          y;
        w = '0;
        for (int r = 0; r < SEG_ROWS; r++) begin
            for (int c = 0; c < SEG_COLS; c++) begin
                dev = r * SEG_COLS + c;
                y   = DEV_SIDE * r + int'(cmd.row);
                // Pixel p of the row lands on data bit 7 - p
                for (int p = 0; p < DEV_SIDE; p++) begin
                    row_bits[DEV_SIDE-1-p] = s.frame[y * FB_XSIZE + DEV_SIDE * c + p];
                end
                case (cmd.kind)
                    CMD_SHUTDOWN:  fr = {4'h0, REG_SHUTDOWN, DATA_SHUTDOWN};
                    CMD_NORMAL:    fr = {4'h0, REG_SHUTDOWN, DATA_NORMAL};
                    CMD_NO_TEST:   fr = {4'h0, REG_TEST, DATA_NO_TEST};
                    CMD_NO_DECODE: fr = {4'h0, REG_DECODE, DATA_NO_DECODE};
                    CMD_SCAN:      fr = {4'h0, REG_SCAN, DATA_SCAN_ALL};
                    CMD_INTENSITY: fr = {4'h0, REG_INTENSITY, 4'h0, s.levels[dev]};
                    default:       fr = {4'h0, REG_DIGIT0 + reg_addr_t'(cmd.row), row_bits};
                endcase
                w[DEV_BITS*dev +: DEV_BITS] = fr;
            end
        end
        return w;
    endfunction

    // Stimulus that follows entry k, inverted copy after the last one
    function automatic stim_t next_stim(int k);
        stim_t s;
        if (k + 1 < NUM_ENTRIES) begin
            s = stim_table[k + 1];
        end else begin
            s        = stim_table[k];
            s.frame  = ~s.frame;
            s.levels = ~s.levels;
        end
        return s;
    endfunction

    task automatic set_inputs(stim_t s);
        frame     = s.frame;
        intensity = s.levels;
    endtask

    task automatic get_word(output chain_word_t w, output int nbits);
        while (word_fifo.size() == 0) begin
            @(negedge clk);
        end
        w     = word_fifo.pop_front();
        nbits = bits_fifo.pop_front();
    endtask

    // ------------------------------------------------------------------
    // SPI capture, sampled on the system clock
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            cap_word = '0;
            cap_bits = 0;
        end else begin
            if (spi_clk && !prev_clk) begin
                cap_word = {cap_word[WIDTH-2:0], spi_din};
                cap_bits++;
            end
            if (spi_stb && !prev_stb) begin
                check_level("o_spi_clk at load", spi_clk, 1'b0);
                word_fifo.push_back(cap_word);
                bits_fifo.push_back(cap_bits);
                cap_word = '0;
                cap_bits = 0;
            end
        end
        prev_clk = spi_clk;
        prev_stb = spi_stb;
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: the DUT sent no further words within %0d clock cycles",
                 LIMIT_CYCLES);
        stop_on_failure();
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        chain_word_t got;
        int          nbits;
        seed          = 72165;
        rst_req       = 1'b0;

        stim_table[0].frame      = 128'h8001_4002_2004_1008_0810_0420_0240_0180;
        stim_table[0].levels     = {4'd12, 4'd3};
        stim_table[0].change_mid = 1'b0;
        // New frame arrives while the rows of this pass are still going out
        stim_table[1].frame      = 128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210;
        stim_table[1].levels     = {4'd0, 4'd15};
        stim_table[1].change_mid = 1'b1;
        stim_table[2].frame      = 128'hFFFF_0000_AAAA_5555_00FF_FF00_C3C3_3C3C;
        stim_table[2].levels     = {4'd9, 4'd7};
        stim_table[2].change_mid = 1'b0;
        stim_table[3].frame      = {$random(seed), $random(seed), $random(seed), $random(seed)};
        stim_table[3].levels[0]  = intensity_t'($random(seed));
        stim_table[3].levels[1]  = intensity_t'($random(seed));
        stim_table[3].change_mid = 1'b0;

        set_inputs(stim_table[0]);

        for (int k = 0; k < NUM_ENTRIES; k++) begin
            for (int w = 0; w < WORDS_PER_PASS; w++) begin
                get_word(got, nbits);
                check_bits($sformatf("o_spi_din bits pass %0d word %0d", k, w), nbits, WIDTH);
                check_word($sformatf("o_spi_din pass %0d word %0d", k, w), got,
                           expected_word(pass_cmd(w), stim_table[k]));
                if ((w == 4 && stim_table[k].change_mid) ||
                    (w == WORDS_PER_PASS - 1 && !stim_table[k].change_mid)) begin
                    @(posedge clk);
                    #1;
                    set_inputs(next_stim(k));
                end
            end
        end

        // Reset in the middle of a shift
        while (spi_stb !== 1'b0) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);
        check_bits("pending words before reset", word_fifo.size(), 0);
        @(posedge clk);
        #1;
        rst_req = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        check_level("o_spi_stb in reset", spi_stb, 1'b1);
        check_level("o_spi_clk in reset", spi_clk, 1'b0);
        check_level("o_spi_din in reset", spi_din, 1'b0);
        rst_req = 1'b0;

        get_word(got, nbits);
        check_bits("o_spi_din bits after reset", nbits, WIDTH);
        check_word("o_spi_din first word after reset", got,
                   expected_word(pass_cmd(0), next_stim(NUM_ENTRIES - 1)));

        $display("TEST PASS");
        $finish;
    end

endmodule
